/* filelist.f */
hdl/qsfp_mgmt_pkg.sv
hdl/board_pkg.sv
hdl/input_debounce.sv
hdl/cmd_decode.sv
hdl/port_ctrl_exec.sv
hdl/resp_format.sv
hdl/qsfp_mgmt_top.sv
sim/tb_qsfp_mgmt.sv

/* hdl/board_pkg.sv */
// Board level facts for the two-cage QSFP management block.
// Cage count, module reset pulse length, input debounce timing and the
// values the control pins take while the block is in reset.

package board_pkg;

    localparam int QSFP_CNT   = 2;
    localparam int CAGE_IDX_W = $clog2(QSFP_CNT);

    // Length of a commanded module reset, in cfgmclk cycles
    localparam int RESET_PULSE_CYCLES = 16;
    localparam int PULSE_CNT_W        = $clog2(RESET_PULSE_CYCLES);

    // Debounce samples every DEBOUNCE_RATE cycles
    localparam int DEBOUNCE_RATE = 4;
    localparam int RATE_CNT_W    = $clog2(DEBOUNCE_RATE);
    // Equal samples needed before a debounced output moves
    localparam int DEBOUNCE_N    = 3;

    // Pin values after reset: module selected, out of reset, high power
    localparam logic RESET_VAL_LPMODE  = 1'b0;
    localparam logic RESET_VAL_MODSELL = 1'b0;
    localparam logic RESET_VAL_RESETL  = 1'b1;

endpackage

/* hdl/cmd_decode.sv */
// Command stage of the QSFP management block.
// Buffers host commands in a small queue, returns one credit per entry
// that leaves, and presents the head entry split into fields together
// with its validity status to the execute stage.

`timescale 1ns/10ps

module cmd_decode
    import qsfp_mgmt_pkg::*, board_pkg::*;
(
    input  logic              cfgmclk_int,
    input  logic              qsfp_refclk_reset_reg,
    input  logic              cmd_valid,
    input  logic [CMD_W-1:0]  cmd_data,
    output logic              cmd_credit,
    output logic              dec_valid,
    input  logic              dec_ready,
    output mgmt_op_t          dec_op,
    output logic [PORT_W-1:0] dec_port,
    output logic [ARG_W-1:0]  dec_arg,
    output resp_status_t      dec_status
);

    logic [CMD_W-1:0]     queue_mem [CMD_QUEUE_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   fill;
    logic [CMD_W-1:0]     head;
    logic                 push;
    logic                 pop;
    logic                 op_known;

    // Host only sends with a credit in hand, full check is a safety net
    assign push = cmd_valid && (fill != (CMD_PTR_W+1)'(CMD_QUEUE_DEPTH));
    assign pop  = dec_valid && dec_ready;

    always_ff @(posedge cfgmclk_int) begin
        if (qsfp_refclk_reset_reg) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // One credit back per popped entry
            cmd_credit <= pop;
        end
    end

    always_ff @(posedge cfgmclk_int) begin
        if (push) begin
            queue_mem[wr_ptr] <= cmd_data;
        end
    end

    // Field split of the head entry
    assign head      = queue_mem[rd_ptr];
    assign dec_valid = (fill != '0);
    assign dec_op    = mgmt_op_t'(head[CMD_W-1 -: OP_W]);
    assign dec_port  = head[ARG_W +: PORT_W];
    assign dec_arg   = head[ARG_W-1:0];

    always_comb begin
        case (dec_op)
            OP_NOP, OP_SET_CTRL, OP_PULSE_RESET, OP_READ_STATUS, OP_READ_CTRL:
                op_known = 1'b1;
            default:
                op_known = 1'b0;
        endcase
    end

    // Unknown opcode wins over a bad port
    assign dec_status = !op_known ? RESP_BAD_OP :
                        (dec_port >= PORT_W'(QSFP_CNT)) ? RESP_BAD_PORT : RESP_OK;

endmodule

/* hdl/input_debounce.sv */
// Debouncer for the module-present and interrupt inputs of every cage.
// Inputs are synchronized, sampled at a fixed rate and a debounced
// output only follows once all recent samples agree.

`timescale 1ns/10ps

module input_debounce
    import board_pkg::*;
(
    input  logic                cfgmclk_int,
    input  logic                qsfp_refclk_reset_reg,
    input  logic [QSFP_CNT-1:0] modprsl,
    input  logic [QSFP_CNT-1:0] intl,
    output logic [QSFP_CNT-1:0] prs_db,
    output logic [QSFP_CNT-1:0] int_db
);

    logic [RATE_CNT_W-1:0]   rate_cnt;
    logic                    sample_tick;
    logic [2*QSFP_CNT-1:0]   in_meta;
    logic [2*QSFP_CNT-1:0]   in_sync;
    logic [2*QSFP_CNT-1:0]   db_out;
    logic [DEBOUNCE_N-1:0]   history [2*QSFP_CNT];

    assign sample_tick = (rate_cnt == RATE_CNT_W'(DEBOUNCE_RATE - 1));

    // Two flop synchronizer, interrupts in the upper half
    always_ff @(posedge cfgmclk_int) begin
        in_meta <= {intl, modprsl};
        in_sync <= in_meta;
    end

    always_ff @(posedge cfgmclk_int) begin
        if (qsfp_refclk_reset_reg) begin
            rate_cnt <= '0;
            // Both inputs active low, so idle means absent and quiet
            db_out <= '1;
            for (int i = 0; i < 2*QSFP_CNT; i++) begin
                history[i] <= '1;
            end
        end else begin
            if (sample_tick) begin
                rate_cnt <= '0;
            end else begin
                rate_cnt <= rate_cnt + 1'b1;
            end

            for (int i = 0; i < 2*QSFP_CNT; i++) begin
                if (sample_tick) begin
                    history[i] <= {history[i][DEBOUNCE_N-2:0], in_sync[i]};
                end
                if (&history[i]) begin
                    db_out[i] <= 1'b1;
                end else if (!(|history[i])) begin
                    db_out[i] <= 1'b0;
                end
            end
        end
    end

    assign prs_db = db_out[QSFP_CNT-1:0];
    assign int_db = db_out[2*QSFP_CNT-1:QSFP_CNT];

endmodule

/* hdl/port_ctrl_exec.sv */
// Execute stage of the QSFP management block.
// Holds the per-cage select, reset and low-power pin registers, runs the
// timed module reset pulse and builds the result for every command.
// Commands arrive already checked, only RESP_OK commands touch the pins.

`timescale 1ns/10ps

module port_ctrl_exec
    import qsfp_mgmt_pkg::*, board_pkg::*;
(
    input  logic                cfgmclk_int,
    input  logic                qsfp_refclk_reset_reg,
    input  logic                dec_valid,
    output logic                dec_ready,
    input  mgmt_op_t            dec_op,
    input  logic [PORT_W-1:0]   dec_port,
    input  logic [ARG_W-1:0]    dec_arg,
    input  resp_status_t        dec_status,
    input  logic [QSFP_CNT-1:0] prs_db,
    input  logic [QSFP_CNT-1:0] int_db,
    output logic                res_valid,
    input  logic                res_ready,
    output resp_status_t        res_status,
    output logic [PORT_W-1:0]   res_port,
    output logic [DATA_W-1:0]   res_data,
    output logic [QSFP_CNT-1:0] qsfp_modsell,
    output logic [QSFP_CNT-1:0] qsfp_resetl,
    output logic [QSFP_CNT-1:0] qsfp_lpmode
);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_PULSE,
        EX_REPLY
    } ex_state_t;

    ex_state_t              state;
    logic [QSFP_CNT-1:0]    modsell_reg;
    logic [QSFP_CNT-1:0]    resetl_reg;
    logic [QSFP_CNT-1:0]    lpmode_reg;
    logic [QSFP_CNT-1:0]    pulse_mask;
    logic [PULSE_CNT_W-1:0] pulse_timer;
    logic [CAGE_IDX_W-1:0]  cage;
    logic [CAGE_IDX_W-1:0]  pulse_cage;
    logic                   take;
    logic                   cmd_ok;
    logic                   pulse_done;

    function automatic logic [DATA_W-1:0] ctrl_word(input logic lp, input logic ms,
                                                     input logic rl);
        logic [DATA_W-1:0] w;
        w = '0;
        w[CTRL_LPMODE_BIT]  = lp;
        w[CTRL_MODSELL_BIT] = ms;
        w[CTRL_RESETL_BIT]  = rl;
        return w;
    endfunction

    assign cage       = dec_port[CAGE_IDX_W-1:0];
    assign pulse_cage = res_port[CAGE_IDX_W-1:0];
    assign cmd_ok     = (dec_status == RESP_OK);
    // Next command may enter while the current result is taken
    assign dec_ready  = (state == EX_IDLE) || ((state == EX_REPLY) && res_ready);
    assign take       = dec_valid && dec_ready;
    assign pulse_done = (state == EX_PULSE) && (pulse_timer == '0);
    assign res_valid  = (state == EX_REPLY);

    always_ff @(posedge cfgmclk_int) begin
        if (qsfp_refclk_reset_reg) begin
            state       <= EX_IDLE;
            modsell_reg <= {QSFP_CNT{RESET_VAL_MODSELL}};
            resetl_reg  <= {QSFP_CNT{RESET_VAL_RESETL}};
            lpmode_reg  <= {QSFP_CNT{RESET_VAL_LPMODE}};
            pulse_mask  <= '0;
            pulse_timer <= '0;
        end else if (state == EX_PULSE) begin
            if (pulse_done) begin
                pulse_mask <= '0;
                state      <= EX_REPLY;
            end else begin
                pulse_timer <= pulse_timer - 1'b1;
            end
        end else if (take) begin
            if (cmd_ok && dec_op == OP_PULSE_RESET) begin
                // Low from the next cycle for RESET_PULSE_CYCLES cycles
                pulse_mask[cage] <= 1'b1;
                pulse_timer      <= PULSE_CNT_W'(RESET_PULSE_CYCLES - 1);
                state            <= EX_PULSE;
            end else begin
                state <= EX_REPLY;
            end
            if (cmd_ok && dec_op == OP_SET_CTRL) begin
                lpmode_reg[cage]  <= dec_arg[CTRL_LPMODE_BIT];
                modsell_reg[cage] <= dec_arg[CTRL_MODSELL_BIT];
                resetl_reg[cage]  <= dec_arg[CTRL_RESETL_BIT];
            end
        end else if (state == EX_REPLY && res_ready) begin
            state <= EX_IDLE;
        end
    end

    // Result word, held until the result stage takes it
    always_ff @(posedge cfgmclk_int) begin
        if (take) begin
            res_status <= dec_status;
            res_port   <= dec_port;
            if (!cmd_ok) begin
                res_data <= '0;
            end else begin
                case (dec_op)
                    OP_SET_CTRL:
                        res_data <= ctrl_word(dec_arg[CTRL_LPMODE_BIT],
                                              dec_arg[CTRL_MODSELL_BIT],
                                              dec_arg[CTRL_RESETL_BIT]);
                    OP_READ_CTRL:
                        res_data <= ctrl_word(lpmode_reg[cage], modsell_reg[cage],
                                              resetl_reg[cage]);
                    OP_READ_STATUS:
                        res_data <= {{(DATA_W-2){1'b0}}, prs_db[cage], int_db[cage]};
                    default:
                        res_data <= '0;
                endcase
            end
        end else if (pulse_done) begin
            // Control value as it stands once the pulse is over
            res_data <= ctrl_word(lpmode_reg[pulse_cage], modsell_reg[pulse_cage],
                                  resetl_reg[pulse_cage]);
        end
    end

    assign qsfp_modsell = modsell_reg;
    assign qsfp_lpmode  = lpmode_reg;
    assign qsfp_resetl  = resetl_reg & ~pulse_mask;

endmodule

/* hdl/qsfp_mgmt_pkg.sv */
// Host management protocol for the QSFP cage controller.
// Defines the command and response word layouts, the opcode and status
// encodings and the queue depths used by the decode and result stages.

package qsfp_mgmt_pkg;

    // Field widths of the command and response words
    localparam int OP_W     = 4;
    localparam int STATUS_W = 4;
    localparam int PORT_W   = 4;
    localparam int ARG_W    = 8;
    localparam int DATA_W   = 8;

    // Command: opcode 15:12, port 11:8, argument 7:0
    localparam int CMD_W  = OP_W + PORT_W + ARG_W;
    // Response: status 15:12, port 11:8, data 7:0
    localparam int RESP_W = STATUS_W + PORT_W + DATA_W;

    typedef enum logic [OP_W-1:0] {
        OP_NOP         = 4'h0,
        OP_SET_CTRL    = 4'h1,
        OP_PULSE_RESET = 4'h2,
        OP_READ_STATUS = 4'h3,
        OP_READ_CTRL   = 4'h4
    } mgmt_op_t;

    typedef enum logic [STATUS_W-1:0] {
        RESP_OK       = 4'h0,
        RESP_BAD_OP   = 4'h1,
        RESP_BAD_PORT = 4'h2
    } resp_status_t;

    // Control pin positions in the SET_CTRL argument and READ_CTRL data
    localparam int CTRL_LPMODE_BIT  = 2;
    localparam int CTRL_MODSELL_BIT = 1;
    localparam int CTRL_RESETL_BIT  = 0;

    localparam int CMD_QUEUE_DEPTH  = 4;
    localparam int RESP_QUEUE_DEPTH = 4;
    localparam int CMD_PTR_W        = $clog2(CMD_QUEUE_DEPTH);
    localparam int RESP_PTR_W       = $clog2(RESP_QUEUE_DEPTH);

    // Width of the host response credit counter
    localparam int CREDIT_W = 8;

endpackage

/* hdl/qsfp_mgmt_top.sv */
// Top level of the QSFP management block for the two-cage board.
// Connects the host command and response ports and the cage pins to the
// debounce, decode, execute and result stages.

`timescale 1ns/10ps

module qsfp_mgmt_top
    import qsfp_mgmt_pkg::*, board_pkg::*;
(
    input  logic                cfgmclk_int,
    input  logic                qsfp_refclk_reset_reg,
    input  logic                cmd_valid,
    input  logic [CMD_W-1:0]    cmd_data,
    output logic                cmd_credit,
    input  logic                resp_credit,
    output logic                resp_valid,
    output logic [RESP_W-1:0]   resp_data,
    input  logic [QSFP_CNT-1:0] qsfp_modprsl,
    input  logic [QSFP_CNT-1:0] qsfp_intl,
    output logic [QSFP_CNT-1:0] qsfp_modsell,
    output logic [QSFP_CNT-1:0] qsfp_resetl,
    output logic [QSFP_CNT-1:0] qsfp_lpmode
);

    logic [QSFP_CNT-1:0] prs_db;
    logic [QSFP_CNT-1:0] int_db;

    logic                dec_valid;
    logic                dec_ready;
    mgmt_op_t            dec_op;
    logic [PORT_W-1:0]   dec_port;
    logic [ARG_W-1:0]    dec_arg;
    resp_status_t        dec_status;

    logic                res_valid;
    logic                res_ready;
    resp_status_t        res_status;
    logic [PORT_W-1:0]   res_port;
    logic [DATA_W-1:0]   res_data;

    input_debounce debounce_i (
        .cfgmclk_int           (cfgmclk_int),
        .qsfp_refclk_reset_reg (qsfp_refclk_reset_reg),
        .modprsl               (qsfp_modprsl),
        .intl                  (qsfp_intl),
        .prs_db                (prs_db),
        .int_db                (int_db)
    );

    cmd_decode decode_i (
        .cfgmclk_int           (cfgmclk_int),
        .qsfp_refclk_reset_reg (qsfp_refclk_reset_reg),
        .cmd_valid             (cmd_valid),
        .cmd_data              (cmd_data),
        .cmd_credit            (cmd_credit),
        .dec_valid             (dec_valid),
        .dec_ready             (dec_ready),
        .dec_op                (dec_op),
        .dec_port              (dec_port),
        .dec_arg               (dec_arg),
        .dec_status            (dec_status)
    );

    port_ctrl_exec exec_i (
        .cfgmclk_int           (cfgmclk_int),
        .qsfp_refclk_reset_reg (qsfp_refclk_reset_reg),
        .dec_valid             (dec_valid),
        .dec_ready             (dec_ready),
        .dec_op                (dec_op),
        .dec_port              (dec_port),
        .dec_arg               (dec_arg),
        .dec_status            (dec_status),
        .prs_db                (prs_db),
        .int_db                (int_db),
        .res_valid             (res_valid),
        .res_ready             (res_ready),
        .res_status            (res_status),
        .res_port              (res_port),
        .res_data              (res_data),
        .qsfp_modsell          (qsfp_modsell),
        .qsfp_resetl           (qsfp_resetl),
        .qsfp_lpmode           (qsfp_lpmode)
    );

    resp_format result_i (
        .cfgmclk_int           (cfgmclk_int),
        .qsfp_refclk_reset_reg (qsfp_refclk_reset_reg),
        .res_valid             (res_valid),
        .res_ready             (res_ready),
        .res_status            (res_status),
        .res_port              (res_port),
        .res_data              (res_data),
        .resp_credit           (resp_credit),
        .resp_valid            (resp_valid),
        .resp_data             (resp_data)
    );

endmodule

/* hdl/resp_format.sv */
// Result stage of the QSFP management block.
// Packs status, port and data into response words, queues them and
// sends one per cycle while the host has response credit available.

`timescale 1ns/10ps

module resp_format
    import qsfp_mgmt_pkg::*;
(
    input  logic              cfgmclk_int,
    input  logic              qsfp_refclk_reset_reg,
    input  logic              res_valid,
    output logic              res_ready,
    input  resp_status_t      res_status,
    input  logic [PORT_W-1:0] res_port,
    input  logic [DATA_W-1:0] res_data,
    input  logic              resp_credit,
    output logic              resp_valid,
    output logic [RESP_W-1:0] resp_data
);

    logic [RESP_W-1:0]     queue_mem [RESP_QUEUE_DEPTH];
    logic [RESP_PTR_W-1:0] wr_ptr;
    logic [RESP_PTR_W-1:0] rd_ptr;
    logic [RESP_PTR_W:0]   fill;
    logic [CREDIT_W-1:0]   credit_cnt;
    logic                  push;
    logic                  send;

    assign res_ready = (fill != (RESP_PTR_W+1)'(RESP_QUEUE_DEPTH));
    assign push      = res_valid && res_ready;
    assign send      = (fill != '0) && (credit_cnt != '0);

    always_ff @(posedge cfgmclk_int) begin
        if (qsfp_refclk_reset_reg) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            credit_cnt <= '0;
            resp_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            credit_cnt <= credit_cnt + CREDIT_W'(resp_credit) - CREDIT_W'(send);
            resp_valid <= send;
        end
    end

    always_ff @(posedge cfgmclk_int) begin
        if (push) begin
            queue_mem[wr_ptr] <= {res_status, res_port, res_data};
        end
        if (send) begin
            resp_data <= queue_mem[rd_ptr];
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the QSFP management testbench with Verilator and runs it.
# Exits with status 0 only when the run reports a pass.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_qsfp_mgmt \
    -Mdir obj_dir \
    -f filelist.f

output="$(./obj_dir/Vtb_qsfp_mgmt)"
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* sim/tb_qsfp_mgmt.sv */
// Self-checking testbench for the QSFP management block.
// Acts as the credit-based host, keeps a model of the pin registers and
// the settled cage inputs, and compares every response and the pins.

`timescale 1ns/10ps

module tb_qsfp_mgmt
    import qsfp_mgmt_pkg::*, board_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 2;
    localparam int DB_BOUND       = (DEBOUNCE_N + 1) * DEBOUNCE_RATE + 2;
    localparam int STATUS_ROUNDS  = 3;
    // Command queue, the item held in execute, and the response queue
    localparam int STALL_CMDS     = CMD_QUEUE_DEPTH + 1 + RESP_QUEUE_DEPTH;
    localparam int TOTAL_CMDS     = QSFP_CNT + 8 + QSFP_CNT*STATUS_ROUNDS + 6
                                    + 2*QSFP_CNT + STALL_CMDS;
    localparam int PER_CMD_CYCLES = 60;
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS*PER_CMD_CYCLES
                                     + STATUS_ROUNDS*(DB_BOUND + 2);

    logic                cfgmclk_int = 1'b0;
    logic                qsfp_refclk_reset_reg;
    logic                cmd_valid;
    logic [CMD_W-1:0]    cmd_data;
    logic                cmd_credit;
    logic                resp_credit;
    logic                resp_valid;
    logic [RESP_W-1:0]   resp_data;
    logic [QSFP_CNT-1:0] qsfp_modprsl;
    logic [QSFP_CNT-1:0] qsfp_intl;
    logic [QSFP_CNT-1:0] qsfp_modsell;
    logic [QSFP_CNT-1:0] qsfp_resetl;
    logic [QSFP_CNT-1:0] qsfp_lpmode;

    // Model of the pin registers and of the settled inputs
    logic [QSFP_CNT-1:0] m_modsell;
    logic [QSFP_CNT-1:0] m_resetl;
    logic [QSFP_CNT-1:0] m_lpmode;
    logic [QSFP_CNT-1:0] m_prs;
    logic [QSFP_CNT-1:0] m_int;

    logic [RESP_W-1:0]   exp_q [$];
    logic [RESP_W-1:0]   exp_word;
    logic [31:0]         lcg_state = 32'd70;
    int                  cmds_sent = 0;
    int                  credits_back = 0;
    int                  resp_count = 0;
    int                  err_count = 0;
    int                  n_checks = 0;
    int                  test_errs = 0;

    qsfp_mgmt_top dut_i (.*);

    always #(CLK_PERIOD/2) cfgmclk_int = ~cfgmclk_int;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Expected response for a command against the current model
    function automatic logic [RESP_W-1:0] ref_resp(input logic [CMD_W-1:0] cmd);
        logic [OP_W-1:0]       op;
        logic [PORT_W-1:0]     port;
        logic [CAGE_IDX_W-1:0] c;
        logic [DATA_W-1:0]     data;
        resp_status_t          st;
        op   = cmd[CMD_W-1 -: OP_W];
        port = cmd[ARG_W +: PORT_W];
        c    = port[CAGE_IDX_W-1:0];
        data = '0;
        st   = (port < PORT_W'(QSFP_CNT)) ? RESP_OK : RESP_BAD_PORT;
        case (op)
            OP_SET_CTRL: begin
                data[CTRL_LPMODE_BIT]  = cmd[CTRL_LPMODE_BIT];
                data[CTRL_MODSELL_BIT] = cmd[CTRL_MODSELL_BIT];
                data[CTRL_RESETL_BIT]  = cmd[CTRL_RESETL_BIT];
            end
            // A pulse reports the stored value once resetl is back
            OP_READ_CTRL, OP_PULSE_RESET: begin
                data[CTRL_LPMODE_BIT]  = m_lpmode[c];
                data[CTRL_MODSELL_BIT] = m_modsell[c];
                data[CTRL_RESETL_BIT]  = m_resetl[c];
            end
            OP_READ_STATUS: data[1:0] = {m_prs[c], m_int[c]};
            OP_NOP:         data = '0;
            default:        st = RESP_BAD_OP;
        endcase
        if (st != RESP_OK) begin
            data = '0;
        end
        return {st, port, data};
    endfunction

    task automatic apply_model(input logic [CMD_W-1:0] cmd);
        logic [CAGE_IDX_W-1:0] c;
        c = cmd[ARG_W +: CAGE_IDX_W];
        if (cmd[CMD_W-1 -: OP_W] == OP_SET_CTRL && cmd[ARG_W +: PORT_W] < PORT_W'(QSFP_CNT)) begin
            m_lpmode[c]  = cmd[CTRL_LPMODE_BIT];
            m_modsell[c] = cmd[CTRL_MODSELL_BIT];
            m_resetl[c]  = cmd[CTRL_RESETL_BIT];
        end
    endtask

    // Waits for a command credit, then drives one command for a cycle
    task automatic send_cmd(input logic [CMD_W-1:0] cmd);
        while (cmds_sent - credits_back >= CMD_QUEUE_DEPTH) begin
            @(negedge cfgmclk_int);
        end
        exp_q.push_back(ref_resp(cmd));
        apply_model(cmd);
        cmd_valid = 1'b1;
        cmd_data  = cmd;
        cmds_sent++;
        @(negedge cfgmclk_int);
        cmd_valid = 1'b0;
    endtask

    task automatic give_resp_credit(input int n);
        repeat (n) begin
            resp_credit = 1'b1;
            @(negedge cfgmclk_int);
        end
        resp_credit = 1'b0;
    endtask

    task automatic wait_drain();
        wait (resp_count == cmds_sent && credits_back == cmds_sent);
        @(negedge cfgmclk_int);
    endtask

    task automatic check_resp(input resp_status_t exp_status,
                              input logic [PORT_W-1:0] exp_port,
                              input logic [DATA_W-1:0] exp_data);
        resp_status_t got_status;
        got_status = resp_status_t'(resp_data[RESP_W-1 -: STATUS_W]);
        n_checks++;
        if (got_status != exp_status) begin
            err_count++;
            $display("Error: resp_data status expected %h got %h", exp_status, got_status);
        end
        if (resp_data[DATA_W +: PORT_W] != exp_port) begin
            err_count++;
            $display("Error: resp_data port expected %h got %h",
                     exp_port, resp_data[DATA_W +: PORT_W]);
        end
        if (resp_data[DATA_W-1:0] != exp_data) begin
            err_count++;
            $display("Error: resp_data data expected %h got %h",
                     exp_data, resp_data[DATA_W-1:0]);
        end
    endtask

    task automatic check_pins(input logic [QSFP_CNT-1:0] exp_modsell,
                              input logic [QSFP_CNT-1:0] exp_resetl,
                              input logic [QSFP_CNT-1:0] exp_lpmode);
        n_checks++;
        if (qsfp_modsell != exp_modsell) begin
            err_count++;
            $display("Error: qsfp_modsell expected %h got %h", exp_modsell, qsfp_modsell);
        end
        if (qsfp_resetl != exp_resetl) begin
            err_count++;
            $display("Error: qsfp_resetl expected %h got %h", exp_resetl, qsfp_resetl);
        end
        if (qsfp_lpmode != exp_lpmode) begin
            err_count++;
            $display("Error: qsfp_lpmode expected %h got %h", exp_lpmode, qsfp_lpmode);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int got);
        n_checks++;
        if (got != exp) begin
            err_count++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s %s with %0d errors", num, name,
                 (err_count == test_errs) ? "passed" : "failed", err_count - test_errs);
        test_errs = err_count;
    endtask

    // Response checker and host credit counters
    always @(negedge cfgmclk_int) begin
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("a response arrived with no command outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                check_resp(resp_status_t'(exp_word[RESP_W-1 -: STATUS_W]),
                           exp_word[DATA_W +: PORT_W], exp_word[DATA_W-1:0]);
            end
            resp_count <= resp_count + 1;
        end
        if (cmd_credit) begin
            credits_back <= credits_back + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with the test still running",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [15:0]           r;
        logic [QSFP_CNT-1:0]   mask;
        logic [CAGE_IDX_W-1:0] cg;
        int                    low_cycles;
        int                    base_resp;
        int                    base_back;
        cmd_valid             = 1'b0;
        cmd_data              = '0;
        resp_credit           = 1'b0;
        qsfp_modprsl          = '1;
        qsfp_intl             = '1;
        qsfp_refclk_reset_reg = 1'b1;
        m_modsell = {QSFP_CNT{RESET_VAL_MODSELL}};
        m_resetl  = {QSFP_CNT{RESET_VAL_RESETL}};
        m_lpmode  = {QSFP_CNT{RESET_VAL_LPMODE}};
        m_prs     = '1;
        m_int     = '1;
        repeat (RESET_CYCLES) @(posedge cfgmclk_int);
        @(negedge cfgmclk_int);
        qsfp_refclk_reset_reg = 1'b0;

        // Reset values and an idle response port
        check_pins(m_modsell, m_resetl, m_lpmode);
        repeat (8) begin
            @(negedge cfgmclk_int);
            compare_count("resp_valid", 0, int'(resp_valid));
        end
        give_resp_credit(QSFP_CNT);
        for (int c = 0; c < QSFP_CNT; c++) begin
            send_cmd({OP_READ_CTRL, PORT_W'(c), 8'h00});
        end
        wait_drain();
        end_test(1, "reset_state");

        give_resp_credit(8);
        repeat (8) begin
            r = lcg_next();
            send_cmd({OP_SET_CTRL, PORT_W'(r[8]), r[7:0]});
            wait_drain();
            check_pins(m_modsell, m_resetl, m_lpmode);
        end
        end_test(2, "set_ctrl");

        repeat (STATUS_ROUNDS) begin
            r = lcg_next();
            qsfp_modprsl = r[QSFP_CNT-1:0];
            qsfp_intl    = r[2*QSFP_CNT-1:QSFP_CNT];
            m_prs        = r[QSFP_CNT-1:0];
            m_int        = r[2*QSFP_CNT-1:QSFP_CNT];
            // Hold the levels past the debounce bound
            repeat (DB_BOUND + 2) @(negedge cfgmclk_int);
            give_resp_credit(QSFP_CNT);
            for (int c = 0; c < QSFP_CNT; c++) begin
                send_cmd({OP_READ_STATUS, PORT_W'(c), r[15:8]});
            end
            wait_drain();
        end
        end_test(3, "read_status");

        give_resp_credit(6);
        repeat (3) begin
            r = lcg_next();
            send_cmd({OP_W'(4'd5 + r[15:12] % 4'd11), PORT_W'(r[8]), r[7:0]});
            r = lcg_next();
            send_cmd({OP_W'(r[15:12] % 4'd5), PORT_W'(4'd2 + r[11:8] % 4'd14), r[7:0]});
        end
        wait_drain();
        check_pins(m_modsell, m_resetl, m_lpmode);
        end_test(4, "errors");

        for (int c = 0; c < QSFP_CNT; c++) begin
            cg = CAGE_IDX_W'(c);
            give_resp_credit(2);
            r = lcg_next();
            // Stored resetl high so the pulse shows as a low period
            r[CTRL_RESETL_BIT] = 1'b1;
            send_cmd({OP_SET_CTRL, PORT_W'(c), r[7:0]});
            wait_drain();
            send_cmd({OP_PULSE_RESET, PORT_W'(c), r[15:8]});
            while (qsfp_resetl[cg]) @(negedge cfgmclk_int);
            mask     = '0;
            mask[cg] = 1'b1;
            check_pins(m_modsell, m_resetl & ~mask, m_lpmode);
            low_cycles = 0;
            while (!qsfp_resetl[cg]) begin
                low_cycles++;
                @(negedge cfgmclk_int);
            end
            compare_count("qsfp_resetl low cycles", RESET_PULSE_CYCLES, low_cycles);
            compare_count("responses at resetl rise", cmds_sent - 1, resp_count);
            wait_drain();
            check_pins(m_modsell, m_resetl, m_lpmode);
        end
        end_test(5, "pulse_reset");

        // No response credit, so the whole pipeline backs up
        base_resp = resp_count;
        base_back = credits_back;
        for (int i = 0; i < STALL_CMDS; i++) begin
            r = lcg_next();
            send_cmd({r[15] ? OP_SET_CTRL : OP_READ_CTRL, PORT_W'(r[8]), r[7:0]});
        end
        repeat (20) @(negedge cfgmclk_int);
        compare_count("responses without credit", base_resp, resp_count);
        compare_count("cmd_credit pulses while stalled", STALL_CMDS - CMD_QUEUE_DEPTH,
                      credits_back - base_back);
        for (int i = 1; i <= STALL_CMDS; i++) begin
            give_resp_credit(1);
            wait (resp_count >= base_resp + i);
            repeat (4) @(negedge cfgmclk_int);
            compare_count("responses per credit", base_resp + i, resp_count);
        end
        compare_count("cmd_credit pulses", STALL_CMDS, credits_back - base_back);
        end_test(6, "credits");

        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("tests 6, checks %0d, errors %0d", n_checks, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
